// ==== sb_params.svh ====
// ------------------------------
// scoreboard parameters
// sizes of the issue buffer, the data path,
// the register file and the writeback ports
// ------------------------------

`ifndef SB_PARAMS_SVH
`define SB_PARAMS_SVH

// buffer depth, kept a power of two
`define SB_NR_ENTRIES 8
// index and transaction id width, 2**bits == entries
`define SB_TRANS_ID_BITS 3

// operand and result width
`define SB_XLEN 32

// general purpose register file
`define SB_REG_ADDR_BITS 5
`define SB_NR_GPR 32

// result ports from the functional units
`define SB_NR_WB_PORTS 2

`endif

// ==== sb_instr_pkg.sv ====
// ------------------------------
// instruction types
// fields that describe one decoded instruction
// and what comes back from its functional unit
// ------------------------------

`include "sb_params.svh"

package sb_instr_pkg;

  // functional unit that executes an instruction
  // NONE completes without a writeback
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    BRANCH = 3'd2,
    LOAD   = 3'd3,
    STORE  = 3'd4,
    MULT   = 3'd5,
    CSR    = 3'd6
  } fu_t;

  // gpr index
  typedef logic [`SB_REG_ADDR_BITS-1:0] reg_addr_t;

  // operand / result word
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // exception cause as reported by the fu
  typedef logic [5:0] ex_cause_t;

endpackage

// ==== sb_queue_pkg.sv ====
// ------------------------------
// buffer bookkeeping types
// entry index and occupancy count
// ------------------------------

`include "sb_params.svh"

package sb_queue_pkg;

  // entry index, doubles as the transaction id
  typedef logic [`SB_TRANS_ID_BITS-1:0] trans_id_t;

  // occupancy count, one bit wider than the index
  // msb set means all entries are in use
  typedef logic [`SB_TRANS_ID_BITS:0] sb_cnt_t;

endpackage

// ==== sb_entry_store.sv ====
// ------------------------------
// scoreboard entry store
// circular buffer of issued instructions with
// issue / commit pointers and occupancy count,
// takes writeback results and flushes
// ------------------------------

`include "sb_params.svh"

module sb_entry_store (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               flush_i,
  input  logic                                               flush_unissued_i,
  // decoder side
  input  logic                                               decoded_valid_i,
  input  sb_instr_pkg::fu_t                                  decoded_fu_i,
  input  sb_instr_pkg::reg_addr_t                            decoded_rd_i,
  output logic                                               decoded_ack_o,
  // issue stage side
  output logic                                               issue_valid_o,
  output sb_queue_pkg::trans_id_t                            issue_trans_id_o,
  input  logic                                               issue_ack_i,
  output logic                                               sb_full_o,
  // writeback ports
  input  logic                      [`SB_NR_WB_PORTS-1:0]    wb_valid_i,
  input  sb_queue_pkg::trans_id_t   [`SB_NR_WB_PORTS-1:0]    wb_trans_id_i,
  input  sb_instr_pkg::xlen_t       [`SB_NR_WB_PORTS-1:0]    wb_data_i,
  input  logic                      [`SB_NR_WB_PORTS-1:0]    wb_ex_valid_i,
  input  sb_instr_pkg::ex_cause_t   [`SB_NR_WB_PORTS-1:0]    wb_ex_cause_i,
  // commit port, shows the oldest entry
  output logic                                               commit_valid_o,
  output sb_queue_pkg::trans_id_t                            commit_trans_id_o,
  output sb_instr_pkg::fu_t                                  commit_fu_o,
  output sb_instr_pkg::reg_addr_t                            commit_rd_o,
  output sb_instr_pkg::xlen_t                                commit_result_o,
  output logic                                               commit_ex_valid_o,
  output sb_instr_pkg::ex_cause_t                            commit_ex_cause_o,
  input  logic                                               commit_ack_i,
  // per-entry state for clobber map and forwarding
  output logic                      [`SB_NR_ENTRIES-1:0]     entry_issued_o,
  output logic                      [`SB_NR_ENTRIES-1:0]     entry_valid_o,
  output sb_instr_pkg::reg_addr_t   [`SB_NR_ENTRIES-1:0]     entry_rd_o,
  output sb_instr_pkg::fu_t         [`SB_NR_ENTRIES-1:0]     entry_fu_o,
  output sb_instr_pkg::xlen_t       [`SB_NR_ENTRIES-1:0]     entry_result_o
);

  import sb_instr_pkg::*;
  import sb_queue_pkg::*;

  // control bits per entry
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_d;
  logic [`SB_NR_ENTRIES-1:0] valid_q, valid_d;
  logic [`SB_NR_ENTRIES-1:0] ex_valid_q, ex_valid_d;

  // payload per entry
  fu_t       [`SB_NR_ENTRIES-1:0] fu_q;
  reg_addr_t [`SB_NR_ENTRIES-1:0] rd_q;
  xlen_t     [`SB_NR_ENTRIES-1:0] result_q;
  ex_cause_t [`SB_NR_ENTRIES-1:0] ex_cause_q;

  trans_id_t issue_ptr_q, issue_ptr_d;
  trans_id_t commit_ptr_q, commit_ptr_d;
  sb_cnt_t   cnt_q, cnt_d;

  logic full;
  logic issue_en;

  // works because the depth is a power of two
  assign full      = cnt_q[`SB_TRANS_ID_BITS];
  assign sb_full_o = full;

  // ------------------------------
  // handshakes
  // ------------------------------
  assign issue_valid_o    = decoded_valid_i & ~full;
  assign decoded_ack_o    = issue_ack_i & ~full;
  assign issue_trans_id_o = issue_ptr_q;
  // an instruction killed in decode is acked but never stored
  assign issue_en         = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  // ------------------------------
  // control next state
  // ------------------------------
  always_comb begin
    issued_d   = issued_q;
    valid_d    = valid_q;
    ex_valid_d = ex_valid_q;

    // new entry, nothing completed yet
    if (issue_en) begin
      issued_d[issue_ptr_q]   = 1'b1;
      valid_d[issue_ptr_q]    = 1'b0;
      ex_valid_d[issue_ptr_q] = 1'b0;
    end

    // no functional unit, done right away
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && fu_q[i] == NONE) begin
        valid_d[i] = 1'b1;
      end
    end

    // results for entries that are still live
    // late results after a flush are dropped here
    for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        valid_d[wb_trans_id_i[k]] = 1'b1;
        if (wb_ex_valid_i[k]) begin
          ex_valid_d[wb_trans_id_i[k]] = 1'b1;
        end
      end
    end

    // retire head
    if (commit_ack_i) begin
      issued_d[commit_ptr_q] = 1'b0;
      valid_d[commit_ptr_q]  = 1'b0;
    end

    if (flush_i) begin
      issued_d   = '0;
      valid_d    = '0;
      ex_valid_d = '0;
    end
  end

  // pointers and count
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + trans_id_t'(commit_ack_i);
  assign cnt_d        = flush_i ? '0
                      : cnt_q + sb_cnt_t'(issue_en) - sb_cnt_t'(commit_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      valid_q      <= '0;
      ex_valid_q   <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      valid_q      <= valid_d;
      ex_valid_q   <= ex_valid_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  // ------------------------------
  // payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (issue_en) begin
      fu_q[issue_ptr_q] <= decoded_fu_i;
      rd_q[issue_ptr_q] <= decoded_rd_i;
    end
    // issue and writeback never hit the same slot
    for (int k = 0; k < `SB_NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        result_q[wb_trans_id_i[k]] <= wb_data_i[k];
        if (wb_ex_valid_i[k]) begin
          ex_cause_q[wb_trans_id_i[k]] <= wb_ex_cause_i[k];
        end
      end
    end
  end

  // head of the buffer
  assign commit_valid_o    = issued_q[commit_ptr_q] & valid_q[commit_ptr_q];
  assign commit_trans_id_o = commit_ptr_q;
  assign commit_fu_o       = fu_q[commit_ptr_q];
  assign commit_rd_o       = rd_q[commit_ptr_q];
  assign commit_result_o   = result_q[commit_ptr_q];
  assign commit_ex_valid_o = ex_valid_q[commit_ptr_q];
  assign commit_ex_cause_o = ex_cause_q[commit_ptr_q];

  assign entry_issued_o = issued_q;
  assign entry_valid_o  = valid_q;
  assign entry_rd_o     = rd_q;
  assign entry_fu_o     = fu_q;
  assign entry_result_o = result_q;

  // ------------------------------
  // protocol checks
  // ------------------------------
  // commit stage only retires a completed head
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_valid_o)
    else $error("commit ack without a valid head entry");

  // issue stage only acks an offered instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue ack without a valid instruction");

  // two fus never retire the same transaction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_valid_i[0] && wb_valid_i[1]) |-> (wb_trans_id_i[0] != wb_trans_id_i[1]))
    else $error("both writeback ports carry the same transaction id");

endmodule

// ==== sb_clobber_map.sv ====
// ------------------------------
// destination clobber map
// for every gpr, the fu of the oldest-slot
// issued entry that will write it
// ------------------------------

`include "sb_params.svh"

module sb_clobber_map (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                    [`SB_NR_ENTRIES-1:0]   entry_issued_i,
  input  sb_instr_pkg::reg_addr_t [`SB_NR_ENTRIES-1:0]   entry_rd_i,
  input  sb_instr_pkg::fu_t       [`SB_NR_ENTRIES-1:0]   entry_fu_i,
  output sb_instr_pkg::fu_t       [`SB_NR_GPR-1:0]       rd_clobber_o
);

  import sb_instr_pkg::*;

  always_comb begin
    for (int r = 0; r < `SB_NR_GPR; r++) begin
      // free unless some entry claims it
      rd_clobber_o[r] = NONE;
      // walk downwards so the lowest index wins
      // x0 is hardwired, an entry writing it never claims it
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (entry_issued_i[i] && entry_rd_i[i] != '0 &&
            entry_rd_i[i] == reg_addr_t'(r)) begin
          rd_clobber_o[r] = entry_fu_i[i];
        end
      end
    end
  end

  // x0 stays free whatever the buffer holds
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_clobber_o[0] == NONE)
    else $error("register 0 reported as clobbered");

endmodule

// ==== sb_operand_fwd.sv ====
// ------------------------------
// operand forwarding
// rs1/rs2 lookup, writeback ports first,
// then completed entries in index order
// ------------------------------

`include "sb_params.svh"

module sb_operand_fwd (
  input  sb_instr_pkg::reg_addr_t                           rs1_i,
  input  sb_instr_pkg::reg_addr_t                           rs2_i,
  // stored entry state
  input  logic                      [`SB_NR_ENTRIES-1:0]    entry_issued_i,
  input  logic                      [`SB_NR_ENTRIES-1:0]    entry_valid_i,
  input  sb_instr_pkg::reg_addr_t   [`SB_NR_ENTRIES-1:0]    entry_rd_i,
  input  sb_instr_pkg::xlen_t       [`SB_NR_ENTRIES-1:0]    entry_result_i,
  // results arriving this cycle
  input  logic                      [`SB_NR_WB_PORTS-1:0]   wb_valid_i,
  input  sb_queue_pkg::trans_id_t   [`SB_NR_WB_PORTS-1:0]   wb_trans_id_i,
  input  sb_instr_pkg::xlen_t       [`SB_NR_WB_PORTS-1:0]   wb_data_i,
  input  logic                      [`SB_NR_WB_PORTS-1:0]   wb_ex_valid_i,
  output sb_instr_pkg::xlen_t                               rs1_o,
  output logic                                              rs1_valid_o,
  output sb_instr_pkg::xlen_t                               rs2_o,
  output logic                                              rs2_valid_o
);

  import sb_instr_pkg::*;

  // both operands go through the same search
  reg_addr_t rs_addr  [2];
  xlen_t     rs_data  [2];
  logic      rs_valid [2];

  assign rs_addr[0] = rs1_i;
  assign rs_addr[1] = rs2_i;

  for (genvar o = 0; o < 2; o++) begin : gen_operand
    always_comb begin
      rs_valid[o] = 1'b0;
      rs_data[o]  = '0;
      // lowest priority first, later hits overwrite
      // completed entries, entry 0 strongest
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (entry_issued_i[i] && entry_valid_i[i] && entry_rd_i[i] == rs_addr[o]) begin
          rs_valid[o] = 1'b1;
          rs_data[o]  = entry_result_i[i];
        end
      end
      // same-cycle results beat stored ones, port 0 strongest
      // a faulting result is never forwarded
      for (int k = `SB_NR_WB_PORTS - 1; k >= 0; k--) begin
        if (wb_valid_i[k] && !wb_ex_valid_i[k] &&
            entry_rd_i[wb_trans_id_i[k]] == rs_addr[o]) begin
          rs_valid[o] = 1'b1;
          rs_data[o]  = wb_data_i[k];
        end
      end
      // x0 reads from the register file
      if (rs_addr[o] == '0) begin
        rs_valid[o] = 1'b0;
        rs_data[o]  = '0;
      end
    end
  end

  assign rs1_o       = rs_data[0];
  assign rs1_valid_o = rs_valid[0];
  assign rs2_o       = rs_data[1];
  assign rs2_valid_o = rs_valid[1];

endmodule

// ==== sb_top.sv ====
// ------------------------------
// instruction scoreboard
// tracks issued instructions until commit,
// drives clobber map and operand forwarding
// ------------------------------

`include "sb_params.svh"

module sb_top (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             flush_i,
  input  logic                                             flush_unissued_i,
  input  logic                                             decoded_valid_i,
  input  sb_instr_pkg::fu_t                                decoded_fu_i,
  input  sb_instr_pkg::reg_addr_t                          decoded_rd_i,
  output logic                                             decoded_ack_o,
  output logic                                             issue_valid_o,
  output sb_queue_pkg::trans_id_t                          issue_trans_id_o,
  input  logic                                             issue_ack_i,
  output logic                                             sb_full_o,
  input  logic                    [`SB_NR_WB_PORTS-1:0]    wb_valid_i,
  input  sb_queue_pkg::trans_id_t [`SB_NR_WB_PORTS-1:0]    wb_trans_id_i,
  input  sb_instr_pkg::xlen_t     [`SB_NR_WB_PORTS-1:0]    wb_data_i,
  input  logic                    [`SB_NR_WB_PORTS-1:0]    wb_ex_valid_i,
  input  sb_instr_pkg::ex_cause_t [`SB_NR_WB_PORTS-1:0]    wb_ex_cause_i,
  output logic                                             commit_valid_o,
  output sb_queue_pkg::trans_id_t                          commit_trans_id_o,
  output sb_instr_pkg::fu_t                                commit_fu_o,
  output sb_instr_pkg::reg_addr_t                          commit_rd_o,
  output sb_instr_pkg::xlen_t                              commit_result_o,
  output logic                                             commit_ex_valid_o,
  output sb_instr_pkg::ex_cause_t                          commit_ex_cause_o,
  input  logic                                             commit_ack_i,
  output sb_instr_pkg::fu_t       [`SB_NR_GPR-1:0]         rd_clobber_o,
  input  sb_instr_pkg::reg_addr_t                          rs1_i,
  input  sb_instr_pkg::reg_addr_t                          rs2_i,
  output sb_instr_pkg::xlen_t                              rs1_o,
  output logic                                             rs1_valid_o,
  output sb_instr_pkg::xlen_t                              rs2_o,
  output logic                                             rs2_valid_o
);

  // entry state shared by the lookups
  logic                    [`SB_NR_ENTRIES-1:0] entry_issued;
  logic                    [`SB_NR_ENTRIES-1:0] entry_valid;
  sb_instr_pkg::reg_addr_t [`SB_NR_ENTRIES-1:0] entry_rd;
  sb_instr_pkg::fu_t       [`SB_NR_ENTRIES-1:0] entry_fu;
  sb_instr_pkg::xlen_t     [`SB_NR_ENTRIES-1:0] entry_result;

  sb_entry_store i_entry_store (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .flush_unissued_i  (flush_unissued_i),
    .decoded_valid_i   (decoded_valid_i),
    .decoded_fu_i      (decoded_fu_i),
    .decoded_rd_i      (decoded_rd_i),
    .decoded_ack_o     (decoded_ack_o),
    .issue_valid_o     (issue_valid_o),
    .issue_trans_id_o  (issue_trans_id_o),
    .issue_ack_i       (issue_ack_i),
    .sb_full_o         (sb_full_o),
    .wb_valid_i        (wb_valid_i),
    .wb_trans_id_i     (wb_trans_id_i),
    .wb_data_i         (wb_data_i),
    .wb_ex_valid_i     (wb_ex_valid_i),
    .wb_ex_cause_i     (wb_ex_cause_i),
    .commit_valid_o    (commit_valid_o),
    .commit_trans_id_o (commit_trans_id_o),
    .commit_fu_o       (commit_fu_o),
    .commit_rd_o       (commit_rd_o),
    .commit_result_o   (commit_result_o),
    .commit_ex_valid_o (commit_ex_valid_o),
    .commit_ex_cause_o (commit_ex_cause_o),
    .commit_ack_i      (commit_ack_i),
    .entry_issued_o    (entry_issued),
    .entry_valid_o     (entry_valid),
    .entry_rd_o        (entry_rd),
    .entry_fu_o        (entry_fu),
    .entry_result_o    (entry_result)
  );

  sb_clobber_map i_clobber_map (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .entry_issued_i (entry_issued),
    .entry_rd_i     (entry_rd),
    .entry_fu_i     (entry_fu),
    .rd_clobber_o   (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .entry_issued_i (entry_issued),
    .entry_valid_i  (entry_valid),
    .entry_rd_i     (entry_rd),
    .entry_result_i (entry_result),
    .wb_valid_i     (wb_valid_i),
    .wb_trans_id_i  (wb_trans_id_i),
    .wb_data_i      (wb_data_i),
    .wb_ex_valid_i  (wb_ex_valid_i),
    .rs1_o          (rs1_o),
    .rs1_valid_o    (rs1_valid_o),
    .rs2_o          (rs2_o),
    .rs2_valid_o    (rs2_valid_o)
  );

endmodule

// ==== tb_sb_top.sv ====
// ------------------------------
// scoreboard testbench
// table of issue / writeback / commit / flush / probe
// steps applied in order against sb_top, with LFSR
// result data and per-step expected outputs
// ------------------------------

`include "sb_params.svh"

module tb_sb_top;

  timeunit 1ns;
  timeprecision 1ps;

  import sb_instr_pkg::*;
  import sb_queue_pkg::*;

  typedef enum logic [2:0] {
    OP_ISSUE, OP_FULL, OP_WB, OP_COMMIT, OP_FLUSH, OP_PROBE
  } op_t;

  // one table row, unused fields stay zero
  typedef struct packed {
    op_t       op;
    logic      kill;
    fu_t       fu;
    reg_addr_t rd;
    trans_id_t id;
    logic      port;
    logic      ex;
    ex_cause_t cause;
    xlen_t     data;
    reg_addr_t rs;
    logic      fwd_valid;
    xlen_t     fwd_data;
    logic      full;
    logic      cvalid;
  } step_t;

  logic                                   clk_i;
  logic                                   rst_ni;
  logic                                   flush_i;
  logic                                   flush_unissued_i;
  logic                                   decoded_valid_i;
  fu_t                                    decoded_fu_i;
  reg_addr_t                              decoded_rd_i;
  logic                                   decoded_ack_o;
  logic                                   issue_valid_o;
  trans_id_t                              issue_trans_id_o;
  logic                                   issue_ack_i;
  logic                                   sb_full_o;
  logic      [`SB_NR_WB_PORTS-1:0]        wb_valid_i;
  trans_id_t [`SB_NR_WB_PORTS-1:0]        wb_trans_id_i;
  xlen_t     [`SB_NR_WB_PORTS-1:0]        wb_data_i;
  logic      [`SB_NR_WB_PORTS-1:0]        wb_ex_valid_i;
  ex_cause_t [`SB_NR_WB_PORTS-1:0]        wb_ex_cause_i;
  logic                                   commit_valid_o;
  trans_id_t                              commit_trans_id_o;
  fu_t                                    commit_fu_o;
  reg_addr_t                              commit_rd_o;
  xlen_t                                  commit_result_o;
  logic                                   commit_ex_valid_o;
  ex_cause_t                              commit_ex_cause_o;
  logic                                   commit_ack_i;
  fu_t       [`SB_NR_GPR-1:0]             rd_clobber_o;
  reg_addr_t                              rs1_i;
  reg_addr_t                              rs2_i;
  xlen_t                                  rs1_o;
  logic                                   rs1_valid_o;
  xlen_t                                  rs2_o;
  logic                                   rs2_valid_o;

  step_t       steps[$];
  xlen_t       d [9];
  logic [31:0] lfsr_state;
  string       cur_test;
  int          errors;
  int          failed_tests;

  sb_top i_sb_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // galois lfsr, taps 32 22 2 1, one step per bit
  function automatic xlen_t lfsr_bits(int n);
    xlen_t v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic string op_name(op_t op);
    case (op)
      OP_ISSUE:  return "issue";
      OP_FULL:   return "full";
      OP_WB:     return "writeback";
      OP_COMMIT: return "commit";
      OP_FLUSH:  return "flush";
      default:   return "probe";
    endcase
  endfunction

  // ------------------------------
  // table rows
  // ------------------------------
  function automatic step_t issue_step(fu_t fu, reg_addr_t rd, trans_id_t id, logic kill);
    step_t s;
    s = '0;
    s.op = OP_ISSUE;
    s.fu = fu;
    s.rd = rd;
    s.id = id;
    s.kill = kill;
    return s;
  endfunction

  function automatic step_t writeback_step(logic port, trans_id_t id, xlen_t data, logic ex,
                                           ex_cause_t cause, reg_addr_t rs, logic fv, xlen_t fd);
    step_t s;
    s = '0;
    s.op = OP_WB;
    s.port = port;
    s.id = id;
    s.data = data;
    s.ex = ex;
    s.cause = cause;
    s.rs = rs;
    s.fwd_valid = fv;
    s.fwd_data = fd;
    return s;
  endfunction

  function automatic step_t commit_step(trans_id_t id, fu_t fu, reg_addr_t rd, xlen_t data,
                                        logic ex, ex_cause_t cause);
    step_t s;
    s = '0;
    s.op = OP_COMMIT;
    s.id = id;
    s.fu = fu;
    s.rd = rd;
    s.data = data;
    s.ex = ex;
    s.cause = cause;
    return s;
  endfunction

  // rd / fu is the clobber lookup, rs the forwarding lookup
  function automatic step_t probe_step(reg_addr_t rd, fu_t fu, reg_addr_t rs, logic fv,
                                       xlen_t fd, logic full, logic cvalid);
    step_t s;
    s = '0;
    s.op = OP_PROBE;
    s.rd = rd;
    s.fu = fu;
    s.rs = rs;
    s.fwd_valid = fv;
    s.fwd_data = fd;
    s.full = full;
    s.cvalid = cvalid;
    return s;
  endfunction

  function automatic step_t other_step(op_t op, reg_addr_t rs);
    step_t s;
    s = '0;
    s.op = op;
    s.rs = rs;
    return s;
  endfunction

  task automatic build_table();
    for (int i = 0; i < 9; i++) begin
      d[i] = lfsr_bits(32);
    end
    // idle after reset
    steps.push_back(probe_step(5, NONE, 5, 0, 0, 0, 0));
    // fill, one decode killed before it is stored
    steps.push_back(issue_step(ALU, 5, 0, 0));
    steps.push_back(issue_step(LOAD, 5, 1, 0));
    steps.push_back(issue_step(MULT, 7, 2, 0));
    steps.push_back(issue_step(ALU, 12, 3, 1));
    steps.push_back(issue_step(NONE, 0, 3, 0));
    steps.push_back(issue_step(CSR, 9, 4, 0));
    steps.push_back(issue_step(ALU, 7, 5, 0));
    steps.push_back(issue_step(BRANCH, 0, 6, 0));
    steps.push_back(issue_step(STORE, 0, 7, 0));
    steps.push_back(other_step(OP_FULL, 0));
    // clobber map, lowest live slot per register
    steps.push_back(probe_step(5, ALU, 5, 0, 0, 1, 0));
    steps.push_back(probe_step(7, MULT, 0, 0, 0, 1, 0));
    steps.push_back(probe_step(9, CSR, 0, 0, 0, 1, 0));
    steps.push_back(probe_step(12, NONE, 0, 0, 0, 1, 0));
    steps.push_back(probe_step(20, NONE, 0, 0, 0, 1, 0));
    steps.push_back(probe_step(0, NONE, 0, 0, 0, 1, 0));
    // out of order results, head still pending
    steps.push_back(writeback_step(1, 2, d[2], 0, 0, 7, 1, d[2]));
    steps.push_back(writeback_step(0, 1, d[1], 0, 0, 5, 1, d[1]));
    steps.push_back(probe_step(5, ALU, 5, 1, d[1], 1, 0));
    steps.push_back(writeback_step(0, 0, d[0], 0, 0, 5, 1, d[0]));
    steps.push_back(probe_step(5, ALU, 5, 1, d[0], 1, 1));
    // port 0 result beats the stored entry 2
    steps.push_back(writeback_step(0, 5, d[5], 0, 0, 7, 1, d[5]));
    steps.push_back(probe_step(7, MULT, 7, 1, d[2], 1, 1));
    // faulting result not forwarded
    steps.push_back(writeback_step(1, 4, d[4], 1, 6'd13, 9, 0, 0));
    steps.push_back(probe_step(9, CSR, 9, 1, d[4], 1, 1));
    steps.push_back(writeback_step(0, 6, d[6], 0, 0, 0, 0, 0));
    steps.push_back(writeback_step(1, 7, d[7], 0, 0, 0, 0, 0));
    // in order retire, map moves to the next writer
    steps.push_back(commit_step(0, ALU, 5, d[0], 0, 0));
    steps.push_back(probe_step(5, LOAD, 5, 1, d[1], 0, 1));
    steps.push_back(commit_step(1, LOAD, 5, d[1], 0, 0));
    steps.push_back(probe_step(5, NONE, 5, 0, 0, 0, 1));
    steps.push_back(commit_step(2, MULT, 7, d[2], 0, 0));
    steps.push_back(probe_step(7, ALU, 7, 1, d[5], 0, 1));
    steps.push_back(commit_step(3, NONE, 0, 0, 0, 0));
    steps.push_back(commit_step(4, CSR, 9, d[4], 1, 6'd13));
    steps.push_back(commit_step(5, ALU, 7, d[5], 0, 0));
    steps.push_back(commit_step(6, BRANCH, 0, d[6], 0, 0));
    steps.push_back(commit_step(7, STORE, 0, d[7], 0, 0));
    steps.push_back(probe_step(7, NONE, 7, 0, 0, 0, 0));
    // flush with live entries, then restart at id 0
    steps.push_back(issue_step(ALU, 3, 0, 0));
    steps.push_back(issue_step(LOAD, 4, 1, 0));
    steps.push_back(writeback_step(0, 0, d[8], 0, 0, 3, 1, d[8]));
    steps.push_back(other_step(OP_FLUSH, 3));
    steps.push_back(issue_step(MULT, 3, 0, 0));
    steps.push_back(probe_step(3, MULT, 3, 0, 0, 0, 0));
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic verify_forwarding(input step_t s);
    check_eq("rs1_valid", s.fwd_valid, rs1_valid_o);
    check_eq("rs1_data", s.fwd_data, rs1_o);
    check_eq("rs2_valid", s.fwd_valid, rs2_valid_o);
    check_eq("rs2_data", s.fwd_data, rs2_o);
  endtask

  // ------------------------------
  // step drivers, all start 2 ns after an edge
  // ------------------------------
  task automatic issue_instr(input step_t s);
    int waited;
    waited = 0;
    decoded_valid_i  = 1'b1;
    decoded_fu_i     = s.fu;
    decoded_rd_i     = s.rd;
    flush_unissued_i = s.kill;
    #1;
    while (issue_valid_o !== 1'b1 && waited < 50) begin
      @(posedge clk_i);
      #3;
      waited++;
    end
    if (issue_valid_o !== 1'b1) begin
      $display("timeout in %s: issue_valid_o stayed low for 50 cycles", cur_test);
      errors++;
    end else begin
      // issue stage takes it as soon as it is offered
      issue_ack_i = 1'b1;
      #1;
      check_eq("decoded_ack", 1, decoded_ack_o);
      check_eq("issue_id", s.id, issue_trans_id_o);
    end
    @(posedge clk_i);
    #2;
    decoded_valid_i  = 1'b0;
    issue_ack_i      = 1'b0;
    flush_unissued_i = 1'b0;
  endtask

  // ninth instruction offered to a full buffer
  task automatic hold_when_full();
    decoded_valid_i = 1'b1;
    decoded_fu_i    = ALU;
    decoded_rd_i    = 5'd15;
    repeat (3) begin
      #1;
      check_eq("sb_full", 1, sb_full_o);
      check_eq("issue_valid", 0, issue_valid_o);
      check_eq("decoded_ack", 0, decoded_ack_o);
      @(posedge clk_i);
      #2;
    end
    decoded_valid_i = 1'b0;
  endtask

  task automatic write_back(input step_t s);
    wb_valid_i[s.port]    = 1'b1;
    wb_trans_id_i[s.port] = s.id;
    wb_data_i[s.port]     = s.data;
    wb_ex_valid_i[s.port] = s.ex;
    wb_ex_cause_i[s.port] = s.cause;
    rs1_i = s.rs;
    rs2_i = s.rs;
    #1;
    verify_forwarding(s);
    @(posedge clk_i);
    #2;
    wb_valid_i    = '0;
    wb_ex_valid_i = '0;
  endtask

  task automatic retire_head(input step_t s);
    int waited;
    waited = 0;
    #1;
    while (commit_valid_o !== 1'b1 && waited < 50) begin
      @(posedge clk_i);
      #3;
      waited++;
    end
    if (commit_valid_o !== 1'b1) begin
      $display("timeout in %s: commit_valid_o stayed low for 50 cycles", cur_test);
      errors++;
    end else begin
      check_eq("commit_id", s.id, commit_trans_id_o);
      check_eq("commit_fu", s.fu, commit_fu_o);
      check_eq("commit_rd", s.rd, commit_rd_o);
      check_eq("commit_ex_valid", s.ex, commit_ex_valid_o);
      // fu NONE never gets a result
      if (s.fu != NONE) begin
        check_eq("commit_result", s.data, commit_result_o);
      end
      if (s.ex) begin
        check_eq("commit_ex_cause", s.cause, commit_ex_cause_o);
      end
      commit_ack_i = 1'b1;
      @(posedge clk_i);
      #2;
      commit_ack_i = 1'b0;
    end
  endtask

  task automatic flush_all(input step_t s);
    flush_i = 1'b1;
    rs1_i   = s.rs;
    rs2_i   = s.rs;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    #1;
    check_eq("commit_valid", 0, commit_valid_o);
    check_eq("sb_full", 0, sb_full_o);
    check_eq("rs1_valid", 0, rs1_valid_o);
    check_eq("rs2_valid", 0, rs2_valid_o);
    for (int r = 0; r < `SB_NR_GPR; r++) begin
      check_eq($sformatf("clobber[%0d]", r), NONE, rd_clobber_o[r]);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic probe_outputs(input step_t s);
    rs1_i = s.rs;
    rs2_i = s.rs;
    #1;
    verify_forwarding(s);
    check_eq($sformatf("clobber[%0d]", s.rd), s.fu, rd_clobber_o[s.rd]);
    check_eq("sb_full", s.full, sb_full_o);
    check_eq("commit_valid", s.cvalid, commit_valid_o);
    @(posedge clk_i);
    #2;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int err_before;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    flush_unissued_i = 1'b0;
    decoded_valid_i  = 1'b0;
    decoded_fu_i     = NONE;
    decoded_rd_i     = '0;
    issue_ack_i      = 1'b0;
    wb_valid_i       = '0;
    wb_trans_id_i    = '0;
    wb_data_i        = '0;
    wb_ex_valid_i    = '0;
    wb_ex_cause_i    = '0;
    commit_ack_i     = 1'b0;
    rs1_i            = '0;
    rs2_i            = '0;
    errors           = 0;
    failed_tests     = 0;
    lfsr_state       = 32'hba8f_48c3;
    build_table();

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    foreach (steps[i]) begin
      cur_test   = $sformatf("%0d_%s", i, op_name(steps[i].op));
      err_before = errors;
      case (steps[i].op)
        OP_ISSUE:  issue_instr(steps[i]);
        OP_FULL:   hold_when_full();
        OP_WB:     write_back(steps[i]);
        OP_COMMIT: retire_head(steps[i]);
        OP_FLUSH:  flush_all(steps[i]);
        default:   probe_outputs(steps[i]);
      endcase
      if (errors == err_before) begin
        $display("test %s ok", cur_test);
      end else begin
        $display("test %s failed", cur_test);
        failed_tests++;
      end
    end

    $display("tests run %0d, failed %0d, mismatches %0d", steps.size(), failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
sb_instr_pkg.sv
sb_queue_pkg.sv
sb_entry_store.sv
sb_clobber_map.sv
sb_operand_fwd.sv
sb_top.sv
tb_sb_top.sv

// ==== Bender.yml ====
package:
  name: sb_scoreboard

sources:
  - include_dirs:
      - .
    files:
      - sb_instr_pkg.sv
      - sb_queue_pkg.sv
      - sb_entry_store.sv
      - sb_clobber_map.sv
      - sb_operand_fwd.sv
      - sb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sb_top.sv
